//--- logic/fp_pkg.sv
package fp_pkg;

    localparam int NUM_PORTS = 4;

    typedef logic [7:0]           byte_t;
    typedef logic [NUM_PORTS-1:0] portmap_t;
    typedef logic [10:0]          flen_t;
    typedef logic [47:0]          mac_t;
    typedef logic [9:0]           hash_t;
    typedef logic [19:0]          desc_t;
    typedef logic [127:0]         cell_t;
    typedef logic [6:0]           cell_cnt_t;

    // pointer fifo descriptor layout
    localparam int DESC_LEN_LSB   = 0;
    localparam int DESC_LEN_MSB   = 10;
    localparam int DESC_SRC_LSB   = 12;
    localparam int DESC_PRERT_LSB = 16;

    localparam int    CELL_BYTES  = 16;
    localparam flen_t HDR_BYTES   = 11'd2;

    // byte positions in the frame, counted from 1
    localparam flen_t DA_LAST     = 11'd6;
    localparam flen_t SA_LAST     = 11'd12;
    localparam flen_t ROUTE_READY = 11'd15;

    // first mac byte sits on top, so its lsb is bit 40
    localparam int GROUP_BIT = 40;

    typedef enum logic [1:0] {RD_IDLE, RD_DESC, RD_LOAD, RD_STREAM} rd_state_e;
    typedef enum logic [1:0] {WR_IDLE, WR_HEADER, WR_BODY} wr_state_e;
    typedef enum logic [1:0] {CF_IDLE, CF_CAPTURE, CF_APPLY, CF_HOLD} conf_state_e;
    typedef enum logic [1:0] {
        FWD_BLOCK = 2'd0,
        LRN_BLOCK = 2'd1,
        MIRROR    = 2'd2,
        UNUSED    = 2'd3
    } conf_type_e;

endpackage

//--- logic/frame_reader.sv
`timescale 1ns/100ps

module frame_reader (
    input  logic             clk,
    input  logic             rstn,
    input  fp_pkg::desc_t    i_ptr_dout,
    input  logic             i_ptr_empty,
    input  fp_pkg::byte_t    i_data_dout,
    input  logic             i_cell_bp,
    output logic             o_ptr_rd,
    output logic             o_data_rd,
    output logic             o_frame_start,
    output fp_pkg::flen_t    o_len,
    output fp_pkg::portmap_t o_src_port,
    output fp_pkg::portmap_t o_prert,
    output fp_pkg::byte_t    o_byte,
    output logic             o_byte_vld,
    output fp_pkg::flen_t    o_byte_pos
);

    fp_pkg::rd_state_e state;
    fp_pkg::rd_state_e state_nxt;
    fp_pkg::flen_t     rd_cnt;

    always_comb begin
        state_nxt = state;
        case (state)
            fp_pkg::RD_IDLE: begin
                // back-pressure only holds off a new frame
                if (!i_ptr_empty && !i_cell_bp) begin
                    state_nxt = fp_pkg::RD_DESC;
                end
            end
            fp_pkg::RD_DESC:   state_nxt = fp_pkg::RD_LOAD;
            fp_pkg::RD_LOAD:   state_nxt = fp_pkg::RD_STREAM;
            fp_pkg::RD_STREAM: begin
                if (rd_cnt == o_len) begin
                    state_nxt = fp_pkg::RD_IDLE;
                end
            end
            default: state_nxt = fp_pkg::RD_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state         <= fp_pkg::RD_IDLE;
            rd_cnt        <= '0;
            o_frame_start <= 1'b0;
            o_byte_vld    <= 1'b0;
            o_byte_pos    <= '0;
        end else begin
            state         <= state_nxt;
            o_frame_start <= (state == fp_pkg::RD_LOAD);
            o_byte_vld    <= o_data_rd;
            if (state == fp_pkg::RD_LOAD) begin
                rd_cnt <= fp_pkg::flen_t'(1);
            end else if (o_data_rd) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
            // position follows the read by one cycle, like the data
            if (o_data_rd) begin
                o_byte_pos <= rd_cnt;
            end
        end
    end

    // descriptor word is on the bus one cycle after the strobe
    always_ff @(posedge clk) begin
        if (state == fp_pkg::RD_LOAD) begin
            o_len      <= i_ptr_dout[fp_pkg::DESC_LEN_MSB:fp_pkg::DESC_LEN_LSB];
            o_src_port <= i_ptr_dout[fp_pkg::DESC_SRC_LSB +: fp_pkg::NUM_PORTS];
            o_prert    <= i_ptr_dout[fp_pkg::DESC_PRERT_LSB +: fp_pkg::NUM_PORTS];
        end
    end

    assign o_ptr_rd  = (state == fp_pkg::RD_DESC);
    assign o_data_rd = (state == fp_pkg::RD_STREAM);
    assign o_byte    = i_data_dout;

endmodule

//--- logic/flow_lookup.sv
`timescale 1ns/100ps

module flow_lookup (
    input  logic             clk,
    input  logic             rstn,
    input  logic             i_frame_start,
    input  fp_pkg::portmap_t i_src_port,
    input  fp_pkg::portmap_t i_prert,
    input  fp_pkg::byte_t    i_byte,
    input  logic             i_byte_vld,
    input  fp_pkg::flen_t    i_byte_pos,
    input  fp_pkg::portmap_t i_link,
    input  fp_pkg::portmap_t i_fwd_blk,
    input  fp_pkg::portmap_t i_lrn_blk,
    input  fp_pkg::portmap_t i_mirror,
    input  logic             i_se_ack,
    input  logic             i_se_nak,
    input  logic [15:0]      i_se_result,
    output logic             o_se_req,
    output fp_pkg::mac_t     o_se_mac,
    output fp_pkg::hash_t    o_se_hash,
    output logic             o_se_source,
    output fp_pkg::portmap_t o_se_portmap,
    output fp_pkg::portmap_t o_route
);

    fp_pkg::mac_t     mac_sh;
    fp_pkg::mac_t     mac_now;
    fp_pkg::portmap_t link_fwd;
    fp_pkg::portmap_t da_result;
    fp_pkg::portmap_t route_nxt;
    logic             fwd_ok;
    logic             lrn_ok;
    logic             da_at;
    logic             sa_at;
    logic             route_at;
    logic             da_group;
    logic             da_pend;
    logic             da_miss;

    // mac including the byte on the bus this cycle
    assign mac_now  = {mac_sh[39:0], i_byte};
    assign da_at    = i_byte_vld && (i_byte_pos == fp_pkg::DA_LAST);
    assign sa_at    = i_byte_vld && (i_byte_pos == fp_pkg::SA_LAST);
    assign route_at = i_byte_vld && (i_byte_pos == fp_pkg::ROUTE_READY);

    assign fwd_ok   = (i_src_port & i_fwd_blk) == '0;
    assign lrn_ok   = (i_src_port & i_lrn_blk) == '0;
    // blocked source port forwards nowhere
    assign link_fwd = fwd_ok ? (i_link & ~i_fwd_blk) : '0;

    always_ff @(posedge clk) begin
        if (i_byte_vld) begin
            mac_sh <= mac_now;
        end
        if (da_at || sa_at) begin
            o_se_mac     <= mac_now;
            o_se_hash    <= mac_now[$bits(fp_pkg::hash_t)-1:0];
            o_se_source  <= sa_at;
            o_se_portmap <= i_src_port;
        end
    end

    always_comb begin
        if (i_prert != '0) begin
            route_nxt = i_prert & i_link;
        end else if (da_group || da_miss) begin
            route_nxt = link_fwd & ~i_src_port;
        end else begin
            route_nxt = (da_result & link_fwd) | (i_mirror & ~i_link);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_se_req  <= 1'b0;
            o_route   <= '0;
            da_group  <= 1'b0;
            da_pend   <= 1'b0;
            da_miss   <= 1'b0;
            da_result <= '0;
        end else begin
            o_se_req <= (da_at && !mac_now[fp_pkg::GROUP_BIT] && fwd_ok)
                     || (sa_at && !mac_now[fp_pkg::GROUP_BIT] && lrn_ok);
            if (i_frame_start) begin
                da_pend   <= 1'b0;
                da_miss   <= 1'b0;
                da_result <= '0;
            end else if (o_se_req && !o_se_source) begin
                da_pend <= 1'b1;
            end else if (da_pend && (i_se_ack || i_se_nak)) begin
                // answers to source requests never get here
                da_pend   <= 1'b0;
                da_miss   <= i_se_nak;
                da_result <= i_se_result[fp_pkg::NUM_PORTS-1:0];
            end
            if (da_at) begin
                da_group <= mac_now[fp_pkg::GROUP_BIT];
            end
            if (route_at) begin
                o_route <= route_nxt;
            end
        end
    end

endmodule

//--- logic/cell_writer.sv
`timescale 1ns/100ps

module cell_writer (
    input  logic             clk,
    input  logic             rstn,
    input  logic             i_frame_start,
    input  fp_pkg::flen_t    i_len,
    input  fp_pkg::portmap_t i_src_port,
    input  fp_pkg::byte_t    i_byte,
    input  logic             i_byte_vld,
    input  fp_pkg::portmap_t i_route,
    output fp_pkg::cell_t    o_cell_data,
    output logic             o_cell_wr,
    output logic [15:0]      o_cell_ptr,
    output logic             o_cell_ptr_wr
);

    typedef logic [$clog2(fp_pkg::CELL_BYTES)-1:0] slot_t;

    fp_pkg::wr_state_e state;
    fp_pkg::cell_t     cell_q;
    fp_pkg::flen_t     stream_len;
    fp_pkg::flen_t     remain;
    fp_pkg::cell_cnt_t cells;
    slot_t             slot;
    logic              take;
    logic              last;
    logic              full;

    assign stream_len = i_len + fp_pkg::HDR_BYTES;
    assign take       = i_byte_vld && (state != fp_pkg::WR_IDLE);
    assign last       = (remain == fp_pkg::flen_t'(1));
    assign full       = &slot;

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state         <= fp_pkg::WR_IDLE;
            slot          <= '0;
            remain        <= '0;
            cells         <= '0;
            o_cell_wr     <= 1'b0;
            o_cell_ptr_wr <= 1'b0;
        end else begin
            o_cell_wr     <= take && (full || last);
            o_cell_ptr_wr <= take && last;
            case (state)
                fp_pkg::WR_IDLE: begin
                    // header goes into the first two slots right away
                    if (i_frame_start) begin
                        state  <= fp_pkg::WR_HEADER;
                        slot   <= slot_t'(fp_pkg::HDR_BYTES);
                        remain <= i_len;
                        cells  <= '0;
                    end
                end
                fp_pkg::WR_HEADER: begin
                    if (i_byte_vld) begin
                        state <= fp_pkg::WR_BODY;
                    end
                end
                fp_pkg::WR_BODY: begin
                    if (i_byte_vld && last) begin
                        state <= fp_pkg::WR_IDLE;
                    end
                end
                default: state <= fp_pkg::WR_IDLE;
            endcase
            if (take) begin
                slot   <= slot + 1'b1;
                remain <= remain - 1'b1;
                if (full) begin
                    cells <= cells + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // cell and pointer data
    ////////////////////////////////////////////////////////////////////////////

    // slot 0 is the top byte of the cell
    always_ff @(posedge clk) begin
        if ((state == fp_pkg::WR_IDLE) && i_frame_start) begin
            cell_q[$bits(fp_pkg::cell_t)-1 -: 16] <= {i_src_port, 1'b0, stream_len};
        end else if (take) begin
            cell_q[(fp_pkg::CELL_BYTES - 1 - int'(slot)) * 8 +: 8] <= i_byte;
        end
        if (take && last) begin
            o_cell_ptr <= {4'b0, i_route, 1'b0, fp_pkg::cell_cnt_t'(cells + 1'b1)};
        end
    end

    assign o_cell_data = cell_q;

endmodule

//--- logic/conf_regs.sv
`timescale 1ns/100ps

module conf_regs (
    input  logic               clk,
    input  logic               rstn,
    input  logic               i_conf_valid,
    input  fp_pkg::conf_type_e i_conf_type,
    input  logic [15:0]        i_conf_data,
    input  logic               i_frame_start,
    output logic               o_conf_resp,
    output fp_pkg::portmap_t   o_fwd_blk,
    output fp_pkg::portmap_t   o_lrn_blk,
    output fp_pkg::portmap_t   o_mirror
);

    fp_pkg::conf_state_e state;
    fp_pkg::conf_type_e  type_q;
    fp_pkg::portmap_t    data_q;
    fp_pkg::portmap_t    fwd_shd;
    fp_pkg::portmap_t    lrn_shd;
    fp_pkg::portmap_t    mir_shd;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= fp_pkg::CF_IDLE;
            fwd_shd   <= '0;
            lrn_shd   <= '0;
            mir_shd   <= '0;
            o_fwd_blk <= '0;
            o_lrn_blk <= '0;
            o_mirror  <= '0;
        end else begin
            case (state)
                fp_pkg::CF_IDLE: begin
                    if (i_conf_valid) begin
                        state <= fp_pkg::CF_CAPTURE;
                    end
                end
                fp_pkg::CF_CAPTURE: state <= fp_pkg::CF_APPLY;
                fp_pkg::CF_APPLY: begin
                    state <= fp_pkg::CF_HOLD;
                    case (type_q)
                        fp_pkg::FWD_BLOCK: fwd_shd <= data_q;
                        fp_pkg::LRN_BLOCK: lrn_shd <= data_q;
                        fp_pkg::MIRROR:    mir_shd <= data_q;
                        default: ;
                    endcase
                end
                fp_pkg::CF_HOLD: begin
                    if (!i_conf_valid) begin
                        state <= fp_pkg::CF_IDLE;
                    end
                end
                default: state <= fp_pkg::CF_IDLE;
            endcase
            // running frame keeps the values it started with
            if (i_frame_start) begin
                o_fwd_blk <= fwd_shd;
                o_lrn_blk <= lrn_shd;
                o_mirror  <= mir_shd;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == fp_pkg::CF_CAPTURE) begin
            type_q <= i_conf_type;
            data_q <= i_conf_data[fp_pkg::NUM_PORTS-1:0];
        end
    end

    assign o_conf_resp = (state == fp_pkg::CF_HOLD);

endmodule

//--- logic/frame_process.sv
`timescale 1ns/100ps

module frame_process (
    input  logic               clk,
    input  logic               rstn,
    input  fp_pkg::desc_t      i_ptr_dout,
    input  logic               i_ptr_empty,
    input  fp_pkg::byte_t      i_data_dout,
    input  logic               i_cell_bp,
    input  fp_pkg::portmap_t   i_link,
    input  logic               i_se_ack,
    input  logic               i_se_nak,
    input  logic [15:0]        i_se_result,
    input  logic               i_conf_valid,
    input  fp_pkg::conf_type_e i_conf_type,
    input  logic [15:0]        i_conf_data,
    output logic               o_ptr_rd,
    output logic               o_data_rd,
    output logic               o_se_req,
    output fp_pkg::mac_t       o_se_mac,
    output fp_pkg::hash_t      o_se_hash,
    output logic               o_se_source,
    output fp_pkg::portmap_t   o_se_portmap,
    output fp_pkg::cell_t      o_cell_data,
    output logic               o_cell_wr,
    output logic [15:0]        o_cell_ptr,
    output logic               o_cell_ptr_wr,
    output logic               o_conf_resp
);

    logic             frame_start;
    fp_pkg::flen_t    len;
    fp_pkg::portmap_t src_port;
    fp_pkg::portmap_t prert;
    fp_pkg::byte_t    byte_d;
    logic             byte_vld;
    fp_pkg::flen_t    byte_pos;
    fp_pkg::portmap_t route;
    fp_pkg::portmap_t fwd_blk;
    fp_pkg::portmap_t lrn_blk;
    fp_pkg::portmap_t mirror;

    frame_reader u_reader (
        .clk, .rstn, .i_ptr_dout, .i_ptr_empty, .i_data_dout, .i_cell_bp,
        .o_ptr_rd, .o_data_rd,
        .o_frame_start (frame_start), .o_len (len), .o_src_port (src_port),
        .o_prert (prert), .o_byte (byte_d), .o_byte_vld (byte_vld),
        .o_byte_pos (byte_pos)
    );

    // lookup requests go out at fixed byte positions
    flow_lookup u_lookup (
        .clk, .rstn, .i_frame_start (frame_start), .i_src_port (src_port),
        .i_prert (prert), .i_byte (byte_d), .i_byte_vld (byte_vld),
        .i_byte_pos (byte_pos), .i_link, .i_fwd_blk (fwd_blk),
        .i_lrn_blk (lrn_blk), .i_mirror (mirror), .i_se_ack, .i_se_nak,
        .i_se_result, .o_se_req, .o_se_mac, .o_se_hash, .o_se_source,
        .o_se_portmap, .o_route (route)
    );

    cell_writer u_writer (
        .clk, .rstn, .i_frame_start (frame_start), .i_len (len),
        .i_src_port (src_port), .i_byte (byte_d), .i_byte_vld (byte_vld),
        .i_route (route), .o_cell_data, .o_cell_wr, .o_cell_ptr, .o_cell_ptr_wr
    );

    conf_regs u_conf (
        .clk, .rstn, .i_conf_valid, .i_conf_type, .i_conf_data,
        .i_frame_start (frame_start), .o_conf_resp,
        .o_fwd_blk (fwd_blk), .o_lrn_blk (lrn_blk), .o_mirror (mirror)
    );

endmodule

//--- dv/frame_process_props.sv
`timescale 1ns/100ps

module frame_process_props (
    input logic clk,
    input logic rstn,
    input logic o_ptr_rd,
    input logic o_data_rd,
    input logic o_se_req,
    input logic o_cell_wr,
    input logic o_cell_ptr_wr
);

    ptr_rd_pulse: assert property (@(posedge clk) disable iff (!rstn) o_ptr_rd |=> !o_ptr_rd)
        else $error("o_ptr_rd longer than one cycle");

    se_req_pulse: assert property (@(posedge clk) disable iff (!rstn) o_se_req |=> !o_se_req)
        else $error("o_se_req longer than one cycle");

    ptr_wr_with_cell: assert property (@(posedge clk) disable iff (!rstn)
        o_cell_ptr_wr |-> o_cell_wr)
        else $error("o_cell_ptr_wr without o_cell_wr");

    // byte reads start two cycles after the pointer read
    no_data_in_desc: assert property (@(posedge clk) disable iff (!rstn)
        o_ptr_rd |-> !o_data_rd ##1 !o_data_rd ##1 o_data_rd)
        else $error("o_data_rd during descriptor fetch or not starting after it");

endmodule

bind frame_process frame_process_props u_props (
    .clk, .rstn, .o_ptr_rd, .o_data_rd, .o_se_req, .o_cell_wr, .o_cell_ptr_wr
);

//--- dv/tb_frame_process.sv
`timescale 1ns/100ps

module tb_frame_process;

    logic               clk;
    logic               rstn;
    fp_pkg::desc_t      i_ptr_dout;
    logic               i_ptr_empty;
    fp_pkg::byte_t      i_data_dout;
    logic               i_cell_bp;
    fp_pkg::portmap_t   i_link;
    logic               i_se_ack;
    logic               i_se_nak;
    logic [15:0]        i_se_result;
    logic               i_conf_valid;
    fp_pkg::conf_type_e i_conf_type;
    logic [15:0]        i_conf_data;
    logic               o_ptr_rd;
    logic               o_data_rd;
    logic               o_se_req;
    fp_pkg::mac_t       o_se_mac;
    fp_pkg::hash_t      o_se_hash;
    logic               o_se_source;
    fp_pkg::portmap_t   o_se_portmap;
    fp_pkg::cell_t      o_cell_data;
    logic               o_cell_wr;
    logic [15:0]        o_cell_ptr;
    logic               o_cell_ptr_wr;
    logic               o_conf_resp;

    frame_process DUT (.*);

    // fifo contents, monitor results and expected frame
    fp_pkg::desc_t    ptr_q[$];
    fp_pkg::byte_t    data_q[$];
    fp_pkg::cell_t    cell_q[$];
    fp_pkg::byte_t    exp_sb[$];
    fp_pkg::mac_t     tbl_mac[2];
    logic [15:0]      tbl_res[2];
    fp_pkg::portmap_t cfg_fwd;
    fp_pkg::portmap_t cfg_lrn;
    fp_pkg::portmap_t cfg_mir;
    fp_pkg::portmap_t exp_src;
    fp_pkg::portmap_t exp_route;
    fp_pkg::portmap_t s_pmap;
    fp_pkg::flen_t    exp_len;
    fp_pkg::mac_t     exp_sa;
    fp_pkg::mac_t     s_mac;
    fp_pkg::hash_t    s_hash;
    logic [15:0]      ptr_seen;
    logic             exp_dreq;
    logic             exp_sreq;
    logic             frame_done;
    logic             s_src;
    logic             req_d1;
    logic             ans_hit;
    logic [15:0]      ans_res;
    int               seed = 92198;
    int               dreq_cnt;
    int               sreq_cnt;
    int               data_rd_cnt;
    int               ptr_rd_cnt;
    int               d0;
    int               s0;

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // fifo, flow table and output models
    ////////////////////////////////////////////////////////////////////////////

    // one cycle read latency on both fifos
    always @(posedge clk) begin
        if (o_ptr_rd) begin
            i_ptr_dout <= ptr_q.pop_front();
        end
        if (o_data_rd) begin
            i_data_dout <= data_q.pop_front();
        end
        i_ptr_empty <= (ptr_q.size() == 0);
    end

    function automatic int find_entry(input fp_pkg::mac_t mac);
        for (int i = 0; i < 2; i++) begin
            if (tbl_mac[i] == mac) begin
                return i;
            end
        end
        return -1;
    endfunction

    // table answers a destination request two cycles later
    always @(posedge clk) begin
        req_d1 <= o_se_req && !o_se_source;
        if (o_se_req && !o_se_source) begin
            ans_hit = (find_entry(o_se_mac) >= 0);
            ans_res = ans_hit ? tbl_res[find_entry(o_se_mac)] : 16'h0;
        end
        i_se_ack    <= req_d1 && ans_hit;
        i_se_nak    <= req_d1 && !ans_hit;
        i_se_result <= req_d1 ? ans_res : 16'h0;
    end

    always @(posedge clk) begin
        if (o_ptr_rd) begin
            data_rd_cnt = 0;
            ptr_rd_cnt++;
        end
        if (o_data_rd) begin
            data_rd_cnt++;
        end
        if (o_cell_wr) begin
            cell_q.push_back(o_cell_data);
        end
        if (o_cell_ptr_wr) begin
            ptr_seen   = o_cell_ptr;
            frame_done = 1'b1;
        end
        if (o_se_req && !o_se_source) begin
            dreq_cnt++;
        end
        if (o_se_req && o_se_source) begin
            sreq_cnt++;
        end
        // learning request comes last in a frame
        if (o_se_req) begin
            s_mac  = o_se_mac;
            s_hash = o_se_hash;
            s_src  = o_se_source;
            s_pmap = o_se_portmap;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checking helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_eq(input string name, input logic [127:0] exp, input logic [127:0] act);
        assert (exp === act) else begin
            $display("Fail at %0t: %s expected %0h actual %0h", $time, name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic stop_run(input string why);
        $display("%s at %0t", why, $time);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    // route rules in priority order
    function automatic fp_pkg::portmap_t expect_route(input fp_pkg::portmap_t prert,
                                                      input fp_pkg::portmap_t src,
                                                      input fp_pkg::mac_t da);
        fp_pkg::portmap_t fwd;
        logic             req;
        int               idx;
        fwd = ((src & cfg_fwd) == 0) ? (i_link & ~cfg_fwd) : 4'b0;
        req = !da[40] && ((src & cfg_fwd) == 0);
        idx = find_entry(da);
        if (prert != 0) begin
            return prert & i_link;
        end
        if (da[40] || (req && idx < 0)) begin
            return fwd & ~src;
        end
        return ((req ? tbl_res[idx][3:0] : 4'b0) & fwd) | (cfg_mir & ~i_link);
    endfunction

    task automatic queue_frame(input fp_pkg::flen_t len, input fp_pkg::portmap_t src,
                               input fp_pkg::portmap_t prert, input fp_pkg::mac_t da,
                               input fp_pkg::mac_t sa);
        logic [10:0]   lenp2;
        fp_pkg::byte_t b;
        lenp2 = len + 11'd2;
        exp_sb.delete();
        exp_sb.push_back({src, 1'b0, lenp2[10:8]});
        exp_sb.push_back(lenp2[7:0]);
        for (int i = 0; i < len; i++) begin
            if (i < 6) begin
                b = da[47 - 8 * i -: 8];
            end else if (i < 12) begin
                b = sa[47 - 8 * (i - 6) -: 8];
            end else begin
                b = $random(seed);
            end
            exp_sb.push_back(b);
            data_q.push_back(b);
        end
        exp_len   = len;
        exp_src   = src;
        exp_sa    = sa;
        exp_route = expect_route(prert, src, da);
        exp_dreq  = !da[40] && ((src & cfg_fwd) == 0);
        exp_sreq  = !sa[40] && ((src & cfg_lrn) == 0);
        d0         = dreq_cnt;
        s0         = sreq_cnt;
        frame_done = 1'b0;
        cell_q.delete();
        ptr_q.push_back({prert, src, 1'b0, len});
    endtask

    task automatic finish_frame();
        int n_cells;
        int cnt;
        n_cells = (exp_len + 2 + 15) / 16;
        cnt = 0;
        while (!frame_done) begin
            @(posedge clk);
            cnt++;
            if (cnt > 4000) begin
                stop_run("timeout waiting for the pointer word write");
            end
        end
        check_eq("o_data_rd cycles", exp_len, data_rd_cnt);
        check_eq("o_cell_wr count", n_cells, cell_q.size());
        for (int k = 0; k < n_cells; k++) begin
            for (int j = 0; j < 16; j++) begin
                if (16 * k + j < exp_sb.size()) begin
                    check_eq($sformatf("o_cell_data cell %0d byte %0d", k, j),
                             exp_sb[16 * k + j], cell_q[k][127 - 8 * j -: 8]);
                end
            end
        end
        check_eq("o_cell_ptr", {4'b0, exp_route, 1'b0, 7'(n_cells)}, ptr_seen);
        check_eq("destination requests", exp_dreq, dreq_cnt - d0);
        check_eq("source requests", exp_sreq, sreq_cnt - s0);
        if (exp_sreq) begin
            check_eq("o_se_mac", exp_sa, s_mac);
            check_eq("o_se_hash", exp_sa[9:0], s_hash);
            check_eq("o_se_source", 1'b1, s_src);
            check_eq("o_se_portmap", exp_src, s_pmap);
        end
    endtask

    task automatic run_frame(input fp_pkg::flen_t len, input fp_pkg::portmap_t src,
                             input fp_pkg::portmap_t prert, input fp_pkg::mac_t da,
                             input fp_pkg::mac_t sa);
        queue_frame(len, src, prert, da, sa);
        finish_frame();
    endtask

    // response must rise on the third edge of the handshake
    task automatic conf_write(input fp_pkg::conf_type_e t, input logic [15:0] d);
        int cnt;
        @(posedge clk);
        i_conf_valid <= 1'b1;
        i_conf_type  <= t;
        i_conf_data  <= d;
        cnt = 0;
        do begin
            @(posedge clk);
            #1;
            cnt++;
            if (cnt > 20) begin
                stop_run("timeout waiting for the configuration response");
            end
        end while (!o_conf_resp);
        check_eq("o_conf_resp rise cycle", 3, cnt);
        @(posedge clk);
        i_conf_valid <= 1'b0;
        #1;
        check_eq("o_conf_resp while valid falls", 1'b1, o_conf_resp);
        @(posedge clk);
        #1;
        check_eq("o_conf_resp after valid falls", 1'b0, o_conf_resp);
        case (t)
            fp_pkg::FWD_BLOCK: cfg_fwd = d[3:0];
            fp_pkg::LRN_BLOCK: cfg_lrn = d[3:0];
            fp_pkg::MIRROR:    cfg_mir = d[3:0];
            default: ;
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic unicast_known();
        run_frame(11'd60, 4'b0001, 4'b0, tbl_mac[0], 48'h0A_00_00_00_01_11);
        run_frame(11'd77, 4'b0010, 4'b0, tbl_mac[1], 48'h0A_00_00_00_02_22);
        run_frame(11'd1518, 4'b0100, 4'b0, tbl_mac[0], 48'h0A_00_00_00_03_33);
    endtask

    task automatic flood_frames();
        run_frame(11'd64, 4'b0010, 4'b0, 48'hFF_FF_FF_FF_FF_FF, 48'h0A_00_00_00_04_44);
        run_frame(11'd90, 4'b0001, 4'b0, 48'h06_12_34_56_78_9A, 48'h0A_00_00_00_05_55);
    endtask

    task automatic preroute_frame();
        run_frame(11'd61, 4'b0001, 4'b1100, tbl_mac[0], 48'h0A_00_00_00_06_66);
    endtask

    task automatic config_writes();
        conf_write(fp_pkg::FWD_BLOCK, 16'h0001);
        run_frame(11'd70, 4'b0001, 4'b0, tbl_mac[0], 48'h0A_00_00_00_07_77);
        conf_write(fp_pkg::FWD_BLOCK, 16'h0000);
        conf_write(fp_pkg::LRN_BLOCK, 16'h0002);
        run_frame(11'd66, 4'b0010, 4'b0, tbl_mac[1], 48'h0A_00_00_00_08_88);
        conf_write(fp_pkg::LRN_BLOCK, 16'h0000);
        conf_write(fp_pkg::MIRROR, 16'h0008);
        run_frame(11'd80, 4'b0001, 4'b0, tbl_mac[1], 48'h0A_00_00_00_09_99);
        // type 3 leaves every vector alone
        conf_write(fp_pkg::UNUSED, 16'h000F);
        run_frame(11'd62, 4'b0100, 4'b0, tbl_mac[0], 48'h0A_00_00_00_0A_AA);
    endtask

    task automatic backpressure_hold();
        int rd0;
        @(posedge clk);
        i_cell_bp <= 1'b1;
        @(posedge clk);
        rd0 = ptr_rd_cnt;
        queue_frame(11'd100, 4'b0010, 4'b0, tbl_mac[0], 48'h0A_00_00_00_0B_BB);
        repeat (12) @(posedge clk);
        check_eq("o_ptr_rd pulses under back-pressure", rd0, ptr_rd_cnt);
        i_cell_bp <= 1'b0;
        finish_frame();
    endtask

    initial begin
        clk          = 1'b0;
        rstn         = 1'b0;
        i_ptr_dout   = '0;
        i_ptr_empty  = 1'b1;
        i_data_dout  = '0;
        i_cell_bp    = 1'b0;
        i_link       = 4'b0111;
        i_se_ack     = 1'b0;
        i_se_nak     = 1'b0;
        i_se_result  = '0;
        i_conf_valid = 1'b0;
        i_conf_type  = fp_pkg::FWD_BLOCK;
        i_conf_data  = '0;
        req_d1       = 1'b0;
        ans_hit      = 1'b0;
        ans_res      = '0;
        cfg_fwd      = '0;
        cfg_lrn      = '0;
        cfg_mir      = '0;
        tbl_mac[0]   = 48'h02_11_22_33_44_55;
        tbl_res[0]   = 16'hA5F6;
        tbl_mac[1]   = 48'h04_66_77_88_99_AA;
        tbl_res[1]   = 16'h3C03;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        unicast_known();
        flood_frames();
        preroute_frame();
        config_writes();
        backpressure_hold();
        repeat (4) @(posedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- files.f
logic/fp_pkg.sv
logic/frame_reader.sv
logic/flow_lookup.sv
logic/cell_writer.sv
logic/conf_regs.sv
logic/frame_process.sv
dv/frame_process_props.sv
dv/tb_frame_process.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the frame processor testbench
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_frame_process \
    -f files.f \
    -o sim_frame_process

./obj_dir/sim_frame_process
